/* hw/ray_pkg.sv */
// signed Q16.16 fixed point only; a zero direction component must arrive as FIX_MAX reciprocal
package ray_pkg;

	// fixed-point word and ray tag widths
	localparam int FIX_W = 32;
	localparam int FRAC_BITS = 16;
	localparam int ID_W = 9;

	// bound minus origin needs one extra bit to stay exact
	localparam int DIFF_W = FIX_W + 1;

	typedef logic signed [FIX_W-1:0] fix_t;
	typedef logic [ID_W-1:0] ray_id_t;

	// saturation limits for scaled products
	localparam fix_t FIX_MAX = {1'b0, {(FIX_W-1){1'b1}}};
	localparam fix_t FIX_MIN = {1'b1, {(FIX_W-1){1'b0}}};

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	// inv_dir holds 1/d per axis, computed by the shader
	typedef struct packed {
		ray_id_t ray_id;
		logic is_shadow;
		vec3_t origin;
		vec3_t inv_dir;
	} ray_t;

	typedef struct packed {
		fix_t xmin;
		fix_t xmax;
		fix_t ymin;
		fix_t ymax;
		fix_t zmin;
		fix_t zmax;
	} aabb_t;

endpackage

/* hw/sint_pkg.sv */
// message layouts only; stack pointer, node ID and restart fields are not carried
package sint_pkg;

	import ray_pkg::*;

	// traversal request for the tree arbiter
	typedef struct packed {
		ray_id_t ray_id;
		logic is_shadow;
		fix_t t_min;
		fix_t t_max;
	} tarb_msg_t;

	// scene exit distance for the stack unit
	typedef struct packed {
		ray_id_t ray_id;
		fix_t t_max_scene;
	} ss_msg_t;

	// missed rays go back to the shader by ID alone
	typedef struct packed {
		ray_id_t ray_id;
	} shader_msg_t;

endpackage

/* hw/sync_fifo.sv */
// single clock queue; writing when full or reading when empty is illegal, DEPTH need not be a power of 2
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic reset,
	input logic [WIDTH-1:0] wdata,
	input logic we,
	input logic re,
	output logic [WIDTH-1:0] rdata,
	output logic full,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic [CW-1:0] count;

	function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
		if (p == AW'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	// head entry, valid whenever not empty
	assign rdata = mem[rptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (we)
				wptr <= bump(wptr);
			if (re)
				rptr <= bump(rptr);
			case ({we, re})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wptr] <= wdata;
	end

	assert property (@(posedge clk) disable iff (reset) !(we && full));
	assert property (@(posedge clk) disable iff (reset) !(re && empty));

endmodule

/* hw/slab_stage.sv */
// two pipeline steps frozen by advance; box must stay constant while rays are in flight
`timescale 1ns/1ns

module slab_stage
	import ray_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic in_valid,
	input ray_t in_ray,
	input aabb_t box,
	output logic out_valid,
	output ray_id_t out_ray_id,
	output logic out_is_shadow,
	output vec3_t t_lo,
	output vec3_t t_hi
);

	// step one: plane offsets from the origin, index 0..2 is x, y, z
	logic s1_valid;
	ray_id_t s1_ray_id;
	logic s1_is_shadow;
	logic signed [DIFF_W-1:0] d_lo [3];
	logic signed [DIFF_W-1:0] d_hi [3];
	vec3_t s1_rcp;

	// (offset * reciprocal) >>> FRAC_BITS, clamped into fix_t
	function automatic fix_t mul_sat(input logic signed [DIFF_W-1:0] d, input fix_t r);
		logic signed [DIFF_W+FIX_W-1:0] prod;
		prod = d * r;
		prod = prod >>> FRAC_BITS;
		if (prod > FIX_MAX)
			return FIX_MAX;
		if (prod < FIX_MIN)
			return FIX_MIN;
		return prod[FIX_W-1:0];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			d_lo[0] <= box.xmin - in_ray.origin.x;
			d_hi[0] <= box.xmax - in_ray.origin.x;
			d_lo[1] <= box.ymin - in_ray.origin.y;
			d_hi[1] <= box.ymax - in_ray.origin.y;
			d_lo[2] <= box.zmin - in_ray.origin.z;
			d_hi[2] <= box.zmax - in_ray.origin.z;
			s1_rcp <= in_ray.inv_dir;
			s1_ray_id <= in_ray.ray_id;
			s1_is_shadow <= in_ray.is_shadow;

			// step two: scaled distances per plane
			t_lo.x <= mul_sat(d_lo[0], s1_rcp.x);
			t_hi.x <= mul_sat(d_hi[0], s1_rcp.x);
			t_lo.y <= mul_sat(d_lo[1], s1_rcp.y);
			t_hi.y <= mul_sat(d_hi[1], s1_rcp.y);
			t_lo.z <= mul_sat(d_lo[2], s1_rcp.z);
			t_hi.z <= mul_sat(d_hi[2], s1_rcp.z);
			out_ray_id <= s1_ray_id;
			out_is_shadow <= s1_is_shadow;
		end
	end

	// valid bits must resolve once out of reset
	assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid));

endmodule

/* hw/interval_stage.sv */
// two pipeline steps frozen by advance; t_min never goes below zero, ties count as a hit
`timescale 1ns/1ns

module interval_stage
	import ray_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic in_valid,
	input ray_id_t in_ray_id,
	input logic in_is_shadow,
	input vec3_t t_lo,
	input vec3_t t_hi,
	output logic out_valid,
	output ray_id_t out_ray_id,
	output logic out_is_shadow,
	output fix_t t_min,
	output fix_t t_max,
	output logic miss
);

	logic s1_valid;
	ray_id_t s1_ray_id;
	logic s1_is_shadow;
	fix_t near_r [3];
	fix_t far_r [3];
	fix_t enter_c;
	fix_t exit_c;

	function automatic fix_t fmin(input fix_t a, input fix_t b);
		return (a < b) ? a : b;
	endfunction

	function automatic fix_t fmax(input fix_t a, input fix_t b);
		return (a > b) ? a : b;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// entry clamped at the ray origin
	always_comb begin
		enter_c = fmax(fmax(near_r[0], near_r[1]), fmax(near_r[2], '0));
		exit_c = fmin(fmin(far_r[0], far_r[1]), far_r[2]);
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			// step one: sort each slab, negative reciprocals swap the planes
			near_r[0] <= fmin(t_lo.x, t_hi.x);
			far_r[0] <= fmax(t_lo.x, t_hi.x);
			near_r[1] <= fmin(t_lo.y, t_hi.y);
			far_r[1] <= fmax(t_lo.y, t_hi.y);
			near_r[2] <= fmin(t_lo.z, t_hi.z);
			far_r[2] <= fmax(t_lo.z, t_hi.z);
			s1_ray_id <= in_ray_id;
			s1_is_shadow <= in_is_shadow;

			// step two: overlap of the three slabs
			t_min <= enter_c;
			t_max <= exit_c;
			miss <= (enter_c > exit_c);
			out_ray_id <= s1_ray_id;
			out_is_shadow <= s1_is_shadow;
		end
	end

endmodule

/* hw/route_stage.sv */
// purely combinational; hold only looks at the queues the current ray needs
`timescale 1ns/1ns

module route_stage
	import ray_pkg::*, sint_pkg::*;
(
	input logic in_valid,
	input ray_id_t ray_id,
	input logic is_shadow,
	input fix_t t_min,
	input fix_t t_max,
	input logic miss,
	input logic tarb_full,
	input logic ss_full,
	input logic shader_full,
	output logic tarb_we,
	output logic ss_we,
	output logic shader_we,
	output tarb_msg_t tarb_wdata,
	output ss_msg_t ss_wdata,
	output shader_msg_t shader_wdata,
	output logic hold
);

	logic is_hit;
	logic is_miss;

	always_comb begin
		is_hit = in_valid && !miss;
		is_miss = in_valid && miss;

		// a hit needs room in both tarb and ss at once
		hold = (is_hit && (tarb_full || ss_full)) || (is_miss && shader_full);

		tarb_we = is_hit && !hold;
		ss_we = is_hit && !hold;
		shader_we = is_miss && !hold;
	end

	// message payloads
	always_comb begin
		tarb_wdata.ray_id = ray_id;
		tarb_wdata.is_shadow = is_shadow;
		tarb_wdata.t_min = t_min;
		tarb_wdata.t_max = t_max;

		ss_wdata.ray_id = ray_id;
		ss_wdata.t_max_scene = t_max;

		shader_wdata.ray_id = ray_id;
	end

	// a valid ray needs a known miss flag and known full flags to be routed
	always_comb begin
		assert (in_valid !== 1'b1 || !$isunknown({miss, tarb_full, ss_full, shader_full}))
			else $error("route_stage: unknown routing input on a valid ray");
	end

endmodule

/* hw/scene_int.sv */
// scene box is a level input that must not change with rays in flight; 5 cycle latency unstalled
`timescale 1ns/1ns

module scene_int
	import ray_pkg::*, sint_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic reset,
	input aabb_t scene_box,

	// rays from the shader
	input logic ray_valid,
	input ray_t ray,
	output logic ray_stall,

	// traversal requests
	output logic tarb_valid,
	output tarb_msg_t tarb_data,
	input logic tarb_stall,

	// scene limits to the stack unit
	output logic ss_valid,
	output ss_msg_t ss_data,
	input logic ss_stall,

	// misses back to the shader
	output logic shader_valid,
	output shader_msg_t shader_data,
	input logic shader_stall
);

	logic hold;
	logic advance;

	logic s_valid;
	ray_id_t s_ray_id;
	logic s_is_shadow;
	vec3_t t_lo;
	vec3_t t_hi;

	logic i_valid;
	ray_id_t i_ray_id;
	logic i_is_shadow;
	fix_t t_min;
	fix_t t_max;
	logic miss;

	logic tarb_we, ss_we, shader_we;
	logic tarb_full, ss_full, shader_full;
	logic tarb_empty, ss_empty, shader_empty;
	tarb_msg_t tarb_wdata;
	ss_msg_t ss_wdata;
	shader_msg_t shader_wdata;

	// whole pipeline moves together
	assign advance = !hold;
	assign ray_stall = hold;

	assign tarb_valid = !tarb_empty;
	assign ss_valid = !ss_empty;
	assign shader_valid = !shader_empty;

	slab_stage slab_inst (
		.clk, .reset, .advance,
		.in_valid(ray_valid), .in_ray(ray), .box(scene_box),
		.out_valid(s_valid), .out_ray_id(s_ray_id), .out_is_shadow(s_is_shadow),
		.t_lo, .t_hi
	);

	interval_stage interval_inst (
		.clk, .reset, .advance,
		.in_valid(s_valid), .in_ray_id(s_ray_id), .in_is_shadow(s_is_shadow),
		.t_lo, .t_hi,
		.out_valid(i_valid), .out_ray_id(i_ray_id), .out_is_shadow(i_is_shadow),
		.t_min, .t_max, .miss
	);

	route_stage route_inst (
		.in_valid(i_valid), .ray_id(i_ray_id), .is_shadow(i_is_shadow),
		.t_min, .t_max, .miss,
		.tarb_full, .ss_full, .shader_full,
		.tarb_we, .ss_we, .shader_we,
		.tarb_wdata, .ss_wdata, .shader_wdata,
		.hold
	);

	sync_fifo #(.WIDTH($bits(tarb_msg_t)), .DEPTH(FIFO_DEPTH)) tarb_fifo (
		.clk, .reset, .wdata(tarb_wdata), .we(tarb_we),
		.re(tarb_valid && !tarb_stall),
		.rdata(tarb_data), .full(tarb_full), .empty(tarb_empty)
	);

	sync_fifo #(.WIDTH($bits(ss_msg_t)), .DEPTH(FIFO_DEPTH)) ss_fifo (
		.clk, .reset, .wdata(ss_wdata), .we(ss_we),
		.re(ss_valid && !ss_stall),
		.rdata(ss_data), .full(ss_full), .empty(ss_empty)
	);

	sync_fifo #(.WIDTH($bits(shader_msg_t)), .DEPTH(FIFO_DEPTH)) shader_fifo (
		.clk, .reset, .wdata(shader_wdata), .we(shader_we),
		.re(shader_valid && !shader_stall),
		.rdata(shader_data), .full(shader_full), .empty(shader_empty)
	);

endmodule

/* tests/scene_int_tb.sv */
// trace replayed seven times; first pass isolated for latency, the rest under random output stalls
`timescale 1ns/1ns

module scene_int_tb
	import ray_pkg::*, sint_pkg::*;
();

	localparam int PASSES = 7;
	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_LIMIT = 5000;

	logic clk;
	logic reset;
	aabb_t scene_box;
	logic ray_valid;
	ray_t ray;
	logic ray_stall;
	logic tarb_valid;
	tarb_msg_t tarb_data;
	logic tarb_stall;
	logic ss_valid;
	ss_msg_t ss_data;
	logic ss_stall;
	logic shader_valid;
	shader_msg_t shader_data;
	logic shader_stall;

	logic [31:0] trace_mem [0:255];
	int n_rays;
	int n_hits;
	int n_miss;
	ray_t rays [$];
	logic ray_hits [$];
	tarb_msg_t exp_tarb [$];
	ss_msg_t exp_ss [$];
	shader_msg_t exp_shader [$];

	int tarb_count;
	int ss_count;
	int shader_count;
	// 0 no stalls, 1 random, 2 random with tarb held
	int stall_mode;
	logic [31:0] lfsr_state;
	logic stall_bit;

	scene_int #(.FIFO_DEPTH(16)) scene_int_inst (
		.clk, .reset, .scene_box,
		.ray_valid, .ray, .ray_stall,
		.tarb_valid, .tarb_data, .tarb_stall,
		.ss_valid, .ss_data, .ss_stall,
		.shader_valid, .shader_data, .shader_stall
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_state = lfsr_next(lfsr_state);
		b = lfsr_state[0];
	endtask

	task automatic check_tarb(input tarb_msg_t got, input tarb_msg_t exp);
		if (got !== exp)
			fail_now($sformatf("error: %0t ns tarb got id %h sh %b %h %h, expected id %h sh %b %h %h",
				$time, got.ray_id, got.is_shadow, got.t_min, got.t_max,
				exp.ray_id, exp.is_shadow, exp.t_min, exp.t_max));
	endtask

	task automatic check_ss(input ss_msg_t got, input ss_msg_t exp);
		if (got !== exp)
			fail_now($sformatf("error: %0t ns ss got id %h t_max %h, expected id %h t_max %h",
				$time, got.ray_id, got.t_max_scene, exp.ray_id, exp.t_max_scene));
	endtask

	task automatic check_shader(input shader_msg_t got, input shader_msg_t exp);
		if (got !== exp)
			fail_now($sformatf("error: %0t ns shader got id %h, expected id %h",
				$time, got.ray_id, exp.ray_id));
	endtask

	task automatic load_trace();
		int p;
		ray_t r;
		tarb_msg_t t;
		ss_msg_t s;
		shader_msg_t m;
		$readmemh("tests/scene_int_trace.txt", trace_mem);
		n_rays = trace_mem[0];
		n_hits = trace_mem[1];
		n_miss = trace_mem[2];
		if (n_rays == 0 || n_hits == 0 || n_miss == 0)
			fail_now("the trace file is missing or has an empty list");
		scene_box = {trace_mem[3], trace_mem[4], trace_mem[5],
			trace_mem[6], trace_mem[7], trace_mem[8]};
		p = 9;
		for (int i = 0; i < n_rays; i++) begin
			r.ray_id = trace_mem[p][8:0];
			r.is_shadow = trace_mem[p+1][0];
			r.origin = {trace_mem[p+2], trace_mem[p+3], trace_mem[p+4]};
			r.inv_dir = {trace_mem[p+5], trace_mem[p+6], trace_mem[p+7]};
			rays.push_back(r);
			ray_hits.push_back(trace_mem[p+8][0]);
			p += 9;
		end
		for (int i = 0; i < n_hits; i++) begin
			t.ray_id = trace_mem[p][8:0];
			t.is_shadow = trace_mem[p+1][0];
			t.t_min = trace_mem[p+2];
			t.t_max = trace_mem[p+3];
			exp_tarb.push_back(t);
			p += 4;
		end
		for (int i = 0; i < n_hits; i++) begin
			s.ray_id = trace_mem[p][8:0];
			s.t_max_scene = trace_mem[p+1];
			exp_ss.push_back(s);
			p += 2;
		end
		for (int i = 0; i < n_miss; i++) begin
			m.ray_id = trace_mem[p][8:0];
			exp_shader.push_back(m);
			p += 1;
		end
	endtask

	// output stalls change 1 ns after each edge
	always @(posedge clk) begin
		#1;
		if (stall_mode == 0) begin
			tarb_stall = 1'b0;
			ss_stall = 1'b0;
			shader_stall = 1'b0;
		end else begin
			take_bit(stall_bit);
			tarb_stall = stall_bit;
			take_bit(stall_bit);
			ss_stall = stall_bit;
			take_bit(stall_bit);
			shader_stall = stall_bit;
			if (stall_mode == 2)
				tarb_stall = 1'b1;
		end
	end

	// a message moves on the next edge when valid and not stalled
	always @(negedge clk) begin
		if (!reset) begin
			if (tarb_valid && !tarb_stall) begin
				if (tarb_count >= PASSES * n_hits)
					fail_now("an extra tarb message arrived after all expected ones");
				check_tarb(tarb_data, exp_tarb[tarb_count % n_hits]);
				tarb_count++;
			end
			if (ss_valid && !ss_stall) begin
				if (ss_count >= PASSES * n_hits)
					fail_now("an extra ss message arrived after all expected ones");
				check_ss(ss_data, exp_ss[ss_count % n_hits]);
				ss_count++;
			end
			if (shader_valid && !shader_stall) begin
				if (shader_count >= PASSES * n_miss)
					fail_now("an extra shader message arrived after all expected ones");
				check_shader(shader_data, exp_shader[shader_count % n_miss]);
				shader_count++;
			end
		end
	end

	task automatic check_idle_outputs(input string when);
		if (ray_stall !== 1'b0 || tarb_valid !== 1'b0 || ss_valid !== 1'b0
				|| shader_valid !== 1'b0)
			fail_now($sformatf("error: %0t ns stall or valid not low %s", $time, when));
	endtask

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic send_ray(input int idx);
		int waited;
		logic accepted;
		ray_valid = 1'b1;
		ray = rays[idx];
		waited = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = !ray_stall;
			@(posedge clk);
			#1;
			waited++;
			if (waited > DRAIN_LIMIT)
				fail_now("timed out waiting for the unit to accept a ray");
		end
	endtask

	// k counts edges from the accepting one to the edge that takes the message
	task automatic check_latency(input logic hit);
		int k;
		k = 0;
		forever begin
			@(negedge clk);
			k++;
			if (hit ? (tarb_valid && ss_valid) : shader_valid)
				break;
			if (k > WAIT_LIMIT)
				fail_now("timed out waiting for an isolated ray to reach its output");
		end
		if (k != 5)
			fail_now($sformatf("error: %0t ns latency %0d cycles, expected 5", $time, k));
		if (hit ? shader_valid : (tarb_valid || ss_valid))
			fail_now($sformatf("error: %0t ns ray showed up on the wrong channel", $time));
	endtask

	task automatic wait_drain();
		int k;
		k = 0;
		do begin
			@(negedge clk);
			k++;
			if (k > WAIT_LIMIT)
				fail_now("timed out waiting for the output queues to drain");
		end while (tarb_valid || ss_valid || shader_valid);
		@(posedge clk);
		#1;
	endtask

	task automatic wait_complete();
		int k;
		k = 0;
		while (tarb_count < PASSES * n_hits || ss_count < PASSES * n_hits
				|| shader_count < PASSES * n_miss) begin
			@(negedge clk);
			k++;
			if (k > DRAIN_LIMIT)
				fail_now("timed out waiting for all expected messages");
		end
	endtask

	task automatic wait_ray_stall();
		int k;
		k = 0;
		do begin
			@(negedge clk);
			k++;
			if (k > DRAIN_LIMIT)
				fail_now("timed out waiting for ray_stall under tarb back-pressure");
		end while (!ray_stall);
	endtask

	initial begin
		reset = 1'b1;
		ray_valid = 1'b0;
		ray = '0;
		scene_box = '0;
		tarb_stall = 1'b0;
		ss_stall = 1'b0;
		shader_stall = 1'b0;
		stall_mode = 0;
		lfsr_state = 32'h992f;
		tarb_count = 0;
		ss_count = 0;
		shader_count = 0;
		load_trace();

		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			check_idle_outputs("during reset");
		end
		reset = 1'b0;
		@(posedge clk);
		#1;
		check_idle_outputs("after reset");

		// isolated rays, latency check
		for (int i = 0; i < n_rays; i++) begin
			send_ray(i);
			ray_valid = 1'b0;
			check_latency(ray_hits[i]);
			wait_drain();
		end

		// back to back under random stalls
		stall_mode = 1;
		for (int p = 0; p < 2; p++)
			for (int i = 0; i < n_rays; i++)
				send_ray(i);
		ray_valid = 1'b0;

		// tarb blocked long enough to fill its queue
		stall_mode = 2;
		fork
			begin
				for (int p = 0; p < 4; p++)
					for (int i = 0; i < n_rays; i++)
						send_ray(i);
				ray_valid = 1'b0;
			end
			begin
				wait_ray_stall();
				repeat (10) @(posedge clk);
				stall_mode = 1;
			end
		join

		wait_complete();
		stall_mode = 0;
		repeat (20) @(posedge clk);
		if (tarb_count == PASSES * n_hits && ss_count == PASSES * n_hits
				&& shader_count == PASSES * n_miss) begin
			$display("Simulation PASSED");
		end else begin
			$display("message counts do not match the trace");
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* scene_int.f */
hw/ray_pkg.sv
hw/sint_pkg.sv
hw/sync_fifo.sv
hw/slab_stage.sv
hw/interval_stage.sv
hw/route_stage.sv
hw/scene_int.sv
tests/scene_int_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= scene_int_tb
FILELIST  ?= scene_int.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/scene_int_trace.txt */
// header: rays hits misses / box: xmin xmax ymin ymax zmin zmax / ray: id shadow ox oy oz rx ry rz hit
// tarb: id shadow t_min t_max / ss: id t_max_scene / shader: id (all Q16.16 words in hex)
00000008 00000005 00000003
00000000 00040000 00000000 00040000 00000000 00040000
// input rays
00000001 00000000 FFFE0000 00010000 00010000 00010000 7FFFFFFF 7FFFFFFF 00000001
00000002 00000001 00010000 00020000 00030000 FFFF0000 00020000 00008000 00000001
00000003 00000000 FFFE0000 00050000 00010000 00010000 7FFFFFFF 7FFFFFFF 00000000
000001FF 00000001 FFFF0000 FFFF0000 FFFF0000 00010000 00010000 00010000 00000001
00000005 00000000 00050000 00050000 00050000 00010000 00010000 00010000 00000000
00000006 00000000 00020000 00020000 FFFC0000 7FFFFFFF 7FFFFFFF 00004000 00000001
00000007 00000001 FFFE0000 FFFE0000 00020000 00010000 FFFF0000 00010000 00000000
00000008 00000000 00030000 00030000 00030000 00010000 00010000 00010000 00000001
// tarb messages
00000001 00000000 00020000 00060000
00000002 00000001 00000000 00008000
000001FF 00000001 00010000 00050000
00000006 00000000 00010000 00020000
00000008 00000000 00000000 00010000
// ss messages
00000001 00060000
00000002 00008000
000001FF 00050000
00000006 00020000
00000008 00010000
// shader messages
00000003
00000005
00000007
